/* rtl/uart_cmd_pkg.sv */
package uart_cmd_pkg;

  // **************************************************
  // bit timing and frame shape.
  // **************************************************

  // clock cycles per bit period, kept small for simulation.
  localparam int BAUD_DIV     = 16;
  localparam int GAP_BITS     = 2;
  localparam int RESP_TIMEOUT = 40;
  // start, eight data bits, even parity, stop.
  localparam int FRAME_BITS   = 11;

  localparam int BAUD_CNT_W = $clog2(BAUD_DIV);
  localparam int BIT_CNT_W  = $clog2(FRAME_BITS + 1);
  localparam int WAIT_CNT_W = $clog2(RESP_TIMEOUT + 1);

  // **************************************************
  // host command and receive result.
  // **************************************************

  // wr set means register write.
  typedef struct packed {
    logic       wr;
    logic [6:0] addr;
    logic [7:0] data;
  } uart_cmd_t;

  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;
    logic       frame_err;
  } uart_rx_byte_t;

  typedef enum logic [2:0] {
    idle,
    send_addr,
    gap,
    send_data,
    wait_resp,
    recv_resp,
    report
  } ctrl_state_e;

endpackage

/* rtl/uart_baud_tick.sv */
`timescale 1ns/10ps

module uart_baud_tick (
  input  logic clk,
  input  logic rst_n,
  input  logic en,
  output logic tick
);

  import uart_cmd_pkg::*;

  logic [BAUD_CNT_W-1:0] cnt;

  // held at full count while disabled, so the first tick is one bit period out.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= BAUD_CNT_W'(BAUD_DIV - 1);
    end else if (!en) begin
      cnt <= BAUD_CNT_W'(BAUD_DIV - 1);
    end else if (cnt == '0) begin
      cnt <= BAUD_CNT_W'(BAUD_DIV - 1);
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

  assign tick = en && (cnt == '0);

endmodule

/* rtl/uart_tx_frame.sv */
`timescale 1ns/10ps

module uart_tx_frame (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  input  logic       bit_tick,
  output logic       bit_en,
  output logic       tx_busy,
  output logic       tx
);

  import uart_cmd_pkg::*;

  logic [FRAME_BITS-1:0] shreg;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic                  parity;
  logic                  load;
  logic                  shift;

  // even parity over the data byte.
  assign parity = ^tx_byte;
  assign load   = tx_start && !tx_busy;
  assign shift  = tx_busy && bit_tick;
  assign bit_en = tx_busy;

  // **************************************************
  // line control.
  // **************************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_busy <= 1'b0;
      tx      <= 1'b1;
      bit_cnt <= '0;
    end else if (load) begin
      tx_busy <= 1'b1;
      tx      <= 1'b0;
      bit_cnt <= '0;
    end else if (shift) begin
      // last tick closes the stop bit.
      if (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1)) begin
        tx_busy <= 1'b0;
        tx      <= 1'b1;
      end else begin
        tx      <= shreg[1];
      end
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // frame image, start bit in bit 0.
  always_ff @(posedge clk) begin
    if (load) begin
      shreg <= {1'b1, parity, tx_byte, 1'b0};
    end else if (shift) begin
      shreg <= {1'b1, shreg[FRAME_BITS-1:1]};
    end
  end

  a_line_idle_high: assert property (
    @(posedge clk) disable iff (!rst_n)
    !tx_busy |-> tx
  );

endmodule

/* rtl/uart_rx_frame.sv */
`timescale 1ns/10ps

module uart_rx_frame (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        rx_en,
  input  logic                        rx,
  output logic                        rx_start_seen,
  output logic                        rx_done,
  output uart_cmd_pkg::uart_rx_byte_t rx_byte
);

  import uart_cmd_pkg::*;

  logic                  rx_s1;
  logic                  rx_s2;
  logic                  rx_q;
  logic                  active;
  logic [BAUD_CNT_W-1:0] cnt;
  logic [BIT_CNT_W-1:0]  bit_idx;
  logic [7:0]            data_sh;
  logic                  par_bit;
  logic                  fall;
  logic                  sample;

  // two-flop synchronizer plus one stage for edge detect.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_q  <= 1'b1;
    end else begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_q  <= rx_s2;
    end
  end

  assign fall   = rx_en && !active && rx_q && !rx_s2;
  assign sample = active && (cnt == '0);

  // **************************************************
  // bit sequencing.
  // **************************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active        <= 1'b0;
      cnt           <= '0;
      bit_idx       <= '0;
      rx_start_seen <= 1'b0;
      rx_done       <= 1'b0;
    end else begin
      rx_start_seen <= 1'b0;
      rx_done       <= 1'b0;
      if (!rx_en) begin
        active <= 1'b0;
      end else if (fall) begin
        // first look lands in the middle of the start bit.
        active  <= 1'b1;
        cnt     <= BAUD_CNT_W'(BAUD_DIV / 2 - 1);
        bit_idx <= '0;
      end else if (active) begin
        if (cnt != '0) begin
          cnt <= cnt - 1'b1;
        end else begin
          cnt     <= BAUD_CNT_W'(BAUD_DIV - 1);
          bit_idx <= bit_idx + 1'b1;
          if (bit_idx == '0) begin
            // a high line here was only a glitch.
            if (rx_s2) begin
              active <= 1'b0;
            end else begin
              rx_start_seen <= 1'b1;
            end
          end else if (bit_idx == BIT_CNT_W'(FRAME_BITS - 1)) begin
            active  <= 1'b0;
            rx_done <= 1'b1;
          end
        end
      end
    end
  end

  // data arrives lsb first, parity then stop.
  always_ff @(posedge clk) begin
    if (sample) begin
      if (bit_idx >= BIT_CNT_W'(1) && bit_idx <= BIT_CNT_W'(8)) begin
        data_sh <= {rx_s2, data_sh[7:1]};
      end
      if (bit_idx == BIT_CNT_W'(9)) begin
        par_bit <= rx_s2;
      end
      if (bit_idx == BIT_CNT_W'(FRAME_BITS - 1)) begin
        rx_byte.data       <= data_sh;
        rx_byte.parity_err <= ^{data_sh, par_bit};
        rx_byte.frame_err  <= !rx_s2;
      end
    end
  end

  a_done_when_enabled: assert property (
    @(posedge clk) disable iff (!rst_n)
    rx_done |-> rx_en
  );

endmodule

/* rtl/uart_cmd_ctrl.sv */
`timescale 1ns/10ps

module uart_cmd_ctrl (
  input  logic                        clk,
  input  logic                        rst_n,
  input  uart_cmd_pkg::uart_cmd_t     cmd_in,
  input  logic                        cmd_vld,
  output logic                        cmd_rdy,
  output logic                        tx_start,
  output logic [7:0]                  tx_byte,
  input  logic                        tx_busy,
  input  logic                        gap_tick,
  output logic                        to_en,
  input  logic                        to_tick,
  output logic                        rx_en,
  input  logic                        rx_start_seen,
  input  logic                        rx_done,
  input  uart_cmd_pkg::uart_rx_byte_t rx_byte,
  output logic                        read_rdy,
  output logic [7:0]                  read_data,
  output logic                        read_err
);

  import uart_cmd_pkg::*;

  ctrl_state_e           state;
  uart_cmd_t             cmd_q;
  logic [WAIT_CNT_W-1:0] bit_cnt;
  logic                  accept;
  logic                  tx_done;
  logic                  gap_end;
  logic                  to_end;
  logic                  resp_end;

  assign cmd_rdy = (state == idle);
  assign accept  = cmd_vld && cmd_rdy;
  // busy is still low in the cycle of the start pulse.
  assign tx_done = !tx_start && !tx_busy;
  assign to_en   = (state == gap) || (state == wait_resp);
  assign rx_en   = (state == wait_resp) || (state == recv_resp);

  assign gap_end  = (state == gap) && gap_tick &&
                    (bit_cnt == WAIT_CNT_W'(GAP_BITS - 1));
  assign to_end   = (state == wait_resp) && !rx_start_seen && to_tick &&
                    (bit_cnt == WAIT_CNT_W'(RESP_TIMEOUT - 1));
  assign resp_end = (state == recv_resp) && rx_done;

  // **************************************************
  // transaction sequencing.
  // **************************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= idle;
      tx_start <= 1'b0;
      bit_cnt  <= '0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
    end else begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      case (state)
        idle: begin
          bit_cnt <= '0;
          if (accept) begin
            state    <= send_addr;
            tx_start <= 1'b1;
          end
        end
        send_addr: begin
          if (tx_done) begin
            state <= cmd_q.wr ? gap : wait_resp;
          end
        end
        gap: begin
          if (gap_end) begin
            state    <= send_data;
            tx_start <= 1'b1;
            bit_cnt  <= '0;
          end else if (gap_tick) begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        send_data: begin
          if (tx_done) begin
            state <= idle;
          end
        end
        wait_resp: begin
          if (rx_start_seen) begin
            state <= recv_resp;
          end else if (to_end) begin
            // device never answered.
            state    <= report;
            read_rdy <= 1'b1;
            read_err <= 1'b1;
          end else if (to_tick) begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        recv_resp: begin
          if (resp_end) begin
            state    <= report;
            read_rdy <= 1'b1;
            read_err <= rx_byte.parity_err || rx_byte.frame_err;
          end
        end
        report: begin
          read_err <= 1'b0;
          state    <= idle;
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // address byte carries the write flag in its msb.
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q   <= cmd_in;
      tx_byte <= {cmd_in.wr, cmd_in.addr};
    end else if (gap_end) begin
      tx_byte <= cmd_q.data;
    end
    if (to_end) begin
      read_data <= '0;
    end else if (resp_end) begin
      read_data <= rx_byte.data;
    end
  end

  a_start_when_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    tx_start |-> !tx_busy
  );

  a_read_rdy_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy
  );

endmodule

/* rtl/uart_cmd_master.sv */
`timescale 1ns/10ps

module uart_cmd_master (
  input  logic                    clk,
  input  logic                    rst_n,
  input  uart_cmd_pkg::uart_cmd_t cmd_in,
  input  logic                    cmd_vld,
  output logic                    cmd_rdy,
  output logic                    tx,
  input  logic                    rx,
  output logic                    read_rdy,
  output logic [7:0]              read_data,
  output logic                    read_err
);

  import uart_cmd_pkg::*;

  logic          tx_start;
  logic [7:0]    tx_byte;
  logic          tx_busy;
  logic          bit_en;
  logic          bit_tick;
  logic          to_en;
  logic          to_tick;
  logic          rx_en;
  logic          rx_start_seen;
  logic          rx_done;
  uart_rx_byte_t rx_byte;

  uart_cmd_ctrl ctrl0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_in        (cmd_in),
    .cmd_vld       (cmd_vld),
    .cmd_rdy       (cmd_rdy),
    .tx_start      (tx_start),
    .tx_byte       (tx_byte),
    .tx_busy       (tx_busy),
    .gap_tick      (to_tick),
    .to_en         (to_en),
    .to_tick       (to_tick),
    .rx_en         (rx_en),
    .rx_start_seen (rx_start_seen),
    .rx_done       (rx_done),
    .rx_byte       (rx_byte),
    .read_rdy      (read_rdy),
    .read_data     (read_data),
    .read_err      (read_err)
  );

  // bit clock for the serializer.
  uart_baud_tick tick_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .en    (bit_en),
    .tick  (bit_tick)
  );

  // gap and response timeout share this one.
  uart_baud_tick tick_to (
    .clk   (clk),
    .rst_n (rst_n),
    .en    (to_en),
    .tick  (to_tick)
  );

  uart_tx_frame tx0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .bit_tick (bit_tick),
    .bit_en   (bit_en),
    .tx_busy  (tx_busy),
    .tx       (tx)
  );

  uart_rx_frame rx0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx_en         (rx_en),
    .rx            (rx),
    .rx_start_seen (rx_start_seen),
    .rx_done       (rx_done),
    .rx_byte       (rx_byte)
  );

endmodule

/* tb/uart_reg_slave_model.sv */
`timescale 1ns/10ps

module uart_reg_slave_model (
  input  logic clk,
  input  logic rst_n,
  input  logic line_in,
  output logic line_out,
  output logic frame_bad
);

  import uart_cmd_pkg::*;

  logic [7:0] regs [0:127];

  // samples one frame at bit centres and returns at the stop bit centre.
  task automatic get_frame(output logic [7:0] b);
    logic [FRAME_BITS-1:0] bits;
    logic                  bad;
    @(negedge line_in);
    repeat (BAUD_DIV / 2) @(negedge clk);
    for (int i = 0; i < FRAME_BITS; i++) begin
      bits[i] = line_in;
      if (i < FRAME_BITS - 1) begin
        repeat (BAUD_DIV) @(negedge clk);
      end
    end
    b   = bits[8:1];
    bad = bits[0] || (^bits[9:1]) || !bits[10];
    if (bad) begin
      @(posedge clk);
      frame_bad <= 1'b1;
      @(posedge clk);
      frame_bad <= 1'b0;
    end
  endtask

  // stop bit is left on the line as the idle level.
  task automatic put_frame(input logic [7:0] b, input logic flip);
    logic [FRAME_BITS-1:0] bits;
    bits = {1'b1, (^b) ^ flip, b, 1'b0};
    @(posedge clk);
    for (int i = 0; i < FRAME_BITS; i++) begin
      line_out <= bits[i];
      if (i < FRAME_BITS - 1) begin
        repeat (BAUD_DIV) @(posedge clk);
      end
    end
  endtask

  initial begin
    logic [7:0] b;
    logic [6:0] a;
    for (int i = 0; i < 128; i++) begin
      regs[i] = 8'(i) ^ 8'h5a;
    end
    line_out  = 1'b1;
    frame_bad = 1'b0;
    forever begin
      wait (rst_n === 1'b1);
      get_frame(b);
      a = b[6:0];
      if (b[7]) begin
        get_frame(b);
        regs[a] = b;
      end else if (a != 7'h7f) begin
        // reply starts three bit periods after the stop bit ends.
        repeat (3 * BAUD_DIV + BAUD_DIV / 2) @(negedge clk);
        put_frame(regs[a], a == 7'h7e);
      end
    end
  end

endmodule

/* tb/uart_cmd_master_tb.sv */
`timescale 1ns/10ps

module uart_cmd_master_tb;

  import uart_cmd_pkg::*;

  localparam int N_DEFAULT   = 4;
  localparam int N_RAND      = 6;
  localparam int NUM_CMDS    = N_DEFAULT + 2 * N_RAND + 3;
  localparam int CMD_LIMIT   = 60 * BAUD_DIV;
  localparam int WR_MIN      = (2 * FRAME_BITS + GAP_BITS) * BAUD_DIV;
  localparam int WATCHDOG_NS = (NUM_CMDS * CMD_LIMIT + 200) * 10;

  logic       clk;
  logic       rst_n;
  uart_cmd_t  cmd_in;
  logic       cmd_vld;
  logic       cmd_rdy;
  logic       tx;
  logic       rx;
  logic       read_rdy;
  logic [7:0] read_data;
  logic       read_err;
  logic       frame_bad;

  logic [7:0] exp_data;
  logic       exp_err;
  logic       chk_data;
  logic       started;
  logic       in_flight;
  logic       in_wr;
  int         age;
  int         errors = 0;
  int         err_base = 0;
  int         tests_run = 0;
  int         seed = 32'h98ef_7290;
  string      test_name;
  logic [7:0] shadow [0:127];
  logic [6:0] rand_addr [0:N_RAND-1];

  uart_cmd_master dut0 (
    .clk (clk), .rst_n (rst_n), .cmd_in (cmd_in), .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy), .tx (tx), .rx (rx), .read_rdy (read_rdy),
    .read_data (read_data), .read_err (read_err)
  );

  uart_reg_slave_model slave0 (
    .clk (clk), .rst_n (rst_n), .line_in (tx), .line_out (rx), .frame_bad (frame_bad)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests completed");
    $display("Finished with errors");
    $finish;
  end

  // age counts cycles since the command was taken.
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_flight <= 1'b0;
      in_wr     <= 1'b0;
      age       <= 0;
    end else if (cmd_vld && cmd_rdy) begin
      in_flight <= 1'b1;
      in_wr     <= cmd_in.wr;
      age       <= 1;
    end else if (in_flight) begin
      age <= age + 1;
      if (cmd_rdy) begin
        in_flight <= 1'b0;
      end
    end
  end

  // **************************************************
  // checks, all sampled on the falling edge.
  // **************************************************
  a_reset_idle: assert property (@(negedge clk) disable iff (!rst_n)
    !started |-> tx && cmd_rdy && !read_rdy && !read_err)
    else begin
      errors++;
      $display("%s: outputs left the idle state before the first command", test_name);
    end

  a_frame_ok: assert property (@(negedge clk) disable iff (!rst_n) !frame_bad)
    else begin
      errors++;
      $display("%s: slave model saw a malformed frame", test_name);
    end

  a_write_length: assert property (@(negedge clk) disable iff (!rst_n)
    in_flight && in_wr && cmd_rdy |-> age >= WR_MIN)
    else begin
      errors++;
      $display("FAIL %s: write length expected >= %0d actual %0d", test_name, WR_MIN, age);
    end

  a_read_end: assert property (@(negedge clk) disable iff (!rst_n)
    in_flight && !in_wr && cmd_rdy |-> $past(read_rdy))
    else begin
      errors++;
      $display("%s: cmd_rdy rose without a read_rdy pulse before it", test_name);
    end

  a_read_err: assert property (@(negedge clk) disable iff (!rst_n)
    read_rdy |-> read_err == exp_err)
    else begin
      errors++;
      $display("FAIL %s: read_err expected %b actual %b", test_name, exp_err, read_err);
    end

  a_read_data: assert property (@(negedge clk) disable iff (!rst_n)
    read_rdy && chk_data |-> read_data == exp_data)
    else begin
      errors++;
      $display("FAIL %s: read_data expected %h actual %h", test_name, exp_data, read_data);
    end

  function automatic logic [6:0] next_addr();
    logic [31:0] r;
    r = $random(seed);
    // 7'h7e and 7'h7f are the faulty addresses.
    return 7'(r[6:0] % 7'd126);
  endfunction

  task automatic issue_cmd(input uart_cmd_t c);
    @(posedge clk);
    cmd_in  <= c;
    cmd_vld <= 1'b1;
    started <= 1'b1;
    @(negedge clk);
    while (!cmd_rdy) @(negedge clk);
    @(posedge clk);
    cmd_vld <= 1'b0;
  endtask

  task automatic wait_done(input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (!cmd_rdy && n < CMD_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!cmd_rdy) begin
      errors++;
      $display("%s: %s did not finish within %0d cycles", test_name, what, CMD_LIMIT);
    end
  endtask

  task automatic write_reg(input logic [6:0] a, input logic [7:0] d);
    shadow[a] = d;
    issue_cmd('{wr: 1'b1, addr: a, data: d});
    wait_done("write");
  endtask

  task automatic read_reg(input logic [6:0] a, input logic [7:0] d, input logic e,
                          input logic chk);
    exp_data <= d;
    exp_err  <= e;
    chk_data <= chk;
    issue_cmd('{wr: 1'b0, addr: a, data: 8'h00});
    wait_done("read");
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_base  = errors;
  endtask

  task automatic report_test();
    tests_run++;
    if (errors == err_base) begin
      $display("test %s: ok", test_name);
    end else begin
      $display("test %s: %0d errors", test_name, errors - err_base);
    end
  endtask

  initial begin
    logic [6:0] a;
    rst_n    = 1'b0;
    cmd_in   = '0;
    cmd_vld  = 1'b0;
    started  = 1'b0;
    exp_data = '0;
    exp_err  = 1'b0;
    chk_data = 1'b0;
    for (int i = 0; i < 128; i++) begin
      shadow[i] = 8'(i) ^ 8'h5a;
    end
    begin_test("reset_idle");
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    repeat (32) @(posedge clk);
    report_test();

    begin_test("default_reads");
    for (int i = 0; i < N_DEFAULT; i++) begin
      a = next_addr();
      read_reg(a, shadow[a], 1'b0, 1'b1);
    end
    report_test();

    begin_test("write_read");
    for (int i = 0; i < N_RAND; i++) begin
      rand_addr[i] = next_addr();
      write_reg(rand_addr[i], 8'($random(seed)));
    end
    for (int i = 0; i < N_RAND; i++) begin
      read_reg(rand_addr[i], shadow[rand_addr[i]], 1'b0, 1'b1);
    end
    report_test();

    begin_test("parity_error");
    read_reg(7'h7e, 8'h00, 1'b1, 1'b0);
    report_test();

    begin_test("no_reply");
    read_reg(7'h7f, 8'h00, 1'b1, 1'b1);
    read_reg(7'h10, shadow[7'h10], 1'b0, 1'b1);
    report_test();

    $display("%0d tests run, %0d errors", tests_run, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* compile.f */
rtl/uart_cmd_pkg.sv
rtl/uart_baud_tick.sv
rtl/uart_tx_frame.sv
rtl/uart_rx_frame.sv
rtl/uart_cmd_ctrl.sv
rtl/uart_cmd_master.sv
tb/uart_reg_slave_model.sv
tb/uart_cmd_master_tb.sv
